// ==== source/sd_macros.svh ====
`ifndef SD_MACROS_SVH
`define SD_MACROS_SVH

// command frame length in bits
`define SD_FRAME_BITS 48
// R1 and R3/R7 response lengths
`define SD_R1_BITS 8
`define SD_R3_BITS 40

// one data block
`define SD_BLOCK_BYTES 512

// attempts for CMD0, and again for ACMD41
`define SD_RETRY_LIMIT 10
// rising edges to wait for a response start bit
`define SD_RESP_TIMEOUT 100
// bytes to wait for the start block token
`define SD_TOKEN_TIMEOUT 1000

`define SD_DATA_TOKEN 8'hFE
`define SD_CHECK_PATTERN 8'hAA
// slow sclk rising edges with cs high after reset
`define SD_POWERUP_CYCLES 80

`endif

// ==== source/sd_pkg.sv ====
`include "sd_macros.svh"

package sd_pkg;

  // full command frame, first bit sent is the msb
  typedef logic [`SD_FRAME_BITS-1:0] sd_frame_t;
  // response, left aligned, first received bit in the msb
  typedef logic [`SD_R3_BITS-1:0] sd_resp_t;
  typedef logic [5:0] sd_cmd_idx_t;
  typedef logic [31:0] sd_arg_t;
  typedef logic [`SD_R1_BITS-1:0] sd_r1_t;
  typedef logic [7:0] sd_byte_t;
  typedef logic [9:0] sd_bit_cnt_t;

  // sequencer states
  // each issue state is directly followed by its wait state
  typedef enum logic [4:0] {
    seq_powerup,
    seq_cmd0,
    seq_cmd0_wait,
    seq_cmd8,
    seq_cmd8_wait,
    seq_cmd58a,
    seq_cmd58a_wait,
    seq_cmd55,
    seq_cmd55_wait,
    seq_acmd41,
    seq_acmd41_wait,
    seq_cmd58b,
    seq_cmd58b_wait,
    seq_cmd16,
    seq_cmd16_wait,
    seq_cmd17,
    seq_cmd17_wait,
    seq_done,
    seq_error
  } sd_seq_state_t;

endpackage

// ==== source/sd_cmd_if.sv ====
`timescale 1ns/1ps

interface sd_cmd_if import sd_pkg::*; ();

  // command request, held from cmd_start until cmd_done
  logic        cmd_start;
  sd_cmd_idx_t cmd_idx;
  sd_arg_t     cmd_arg;
  sd_bit_cnt_t resp_len;
  logic        want_block;
  // chip select request
  logic        cs_active;

  // engine status
  logic        busy;
  logic        cmd_done;
  sd_resp_t    resp;
  logic        resp_timeout;

  modport seq (
    output cmd_start, cmd_idx, cmd_arg, resp_len, want_block, cs_active,
    input  busy, cmd_done, resp, resp_timeout
  );

  modport eng (
    input  cmd_start, cmd_idx, cmd_arg, resp_len, want_block, cs_active,
    output busy, cmd_done, resp, resp_timeout
  );

endinterface

// ==== source/sd_sclk_gen.sv ====
`timescale 1ns/1ps

module sd_sclk_gen #(
  parameter int slow_div = 125,
  parameter int fast_div = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic fast_sel,
  output logic sd_sclk,
  output logic sclk_rise,
  output logic sclk_fall
);

  localparam int max_div = (slow_div > fast_div) ? slow_div : fast_div;
  localparam int cnt_w = $clog2(max_div + 1);

  logic [cnt_w-1:0] cnt;
  // half period in use, reloaded on every toggle
  logic [cnt_w-1:0] cur_div;
  logic             toggle;

  assign toggle = (cnt == cur_div - 1'b1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt       <= '0;
      cur_div   <= cnt_w'(slow_div);
      sd_sclk   <= 1'b0;
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
    end else begin
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
      if (toggle) begin
        cnt       <= '0;
        sd_sclk   <= ~sd_sclk;
        // strobe matches the new sclk level
        sclk_rise <= ~sd_sclk;
        sclk_fall <= sd_sclk;
        // rate change lands here only
        cur_div   <= fast_sel ? cnt_w'(fast_div) : cnt_w'(slow_div);
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

// ==== source/sd_init_sequencer.sv ====
`timescale 1ns/1ps
`include "sd_macros.svh"

module sd_init_sequencer import sd_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sclk_rise,
  sd_cmd_if.seq      link,
  output logic       fast_sel,
  output logic       init_done,
  output logic       init_error,
  output logic       card_high_capacity
);

  sd_seq_state_t state;
  sd_bit_cnt_t   pwr_cnt;
  logic [3:0]    retry_cnt;
  sd_r1_t        r1;

  // status byte sits at the top of the left aligned response
  assign r1 = link.resp[`SD_R3_BITS-1 -: `SD_R1_BITS];

  // command fields follow the state, stable through the wait state
  always_comb begin
    link.cmd_idx    = 6'd0;
    link.cmd_arg    = '0;
    link.resp_len   = sd_bit_cnt_t'(`SD_R1_BITS);
    link.want_block = 1'b0;
    case (state)
      seq_cmd8, seq_cmd8_wait: begin
        // 2.7-3.6 V plus check pattern
        link.cmd_idx  = 6'd8;
        link.cmd_arg  = {20'h0, 4'h1, `SD_CHECK_PATTERN};
        link.resp_len = sd_bit_cnt_t'(`SD_R3_BITS);
      end
      seq_cmd58a, seq_cmd58a_wait, seq_cmd58b, seq_cmd58b_wait: begin
        link.cmd_idx  = 6'd58;
        link.resp_len = sd_bit_cnt_t'(`SD_R3_BITS);
      end
      seq_cmd55, seq_cmd55_wait: link.cmd_idx = 6'd55;
      seq_acmd41, seq_acmd41_wait: begin
        // hcs set, high capacity host
        link.cmd_idx = 6'd41;
        link.cmd_arg = 32'h4000_0000;
      end
      seq_cmd16, seq_cmd16_wait: begin
        link.cmd_idx = 6'd16;
        link.cmd_arg = `SD_BLOCK_BYTES;
      end
      seq_cmd17, seq_cmd17_wait: begin
        // block 0
        link.cmd_idx    = 6'd17;
        link.want_block = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state              <= seq_powerup;
      pwr_cnt            <= '0;
      retry_cnt          <= '0;
      link.cmd_start     <= 1'b0;
      link.cs_active     <= 1'b0;
      fast_sel           <= 1'b0;
      init_done          <= 1'b0;
      init_error         <= 1'b0;
      card_high_capacity <= 1'b0;
    end else begin
      link.cmd_start <= 1'b0;
      case (state)
        seq_powerup: begin
          // card needs 74+ clocks with cs high
          if (sclk_rise) begin
            if (pwr_cnt == `SD_POWERUP_CYCLES - 1) begin
              link.cs_active <= 1'b1;
              state          <= seq_cmd0;
            end else begin
              pwr_cnt <= pwr_cnt + 1'b1;
            end
          end
        end
        seq_cmd0, seq_cmd8, seq_cmd58a, seq_cmd55, seq_acmd41,
        seq_cmd58b, seq_cmd16, seq_cmd17: begin
          if (!link.busy) begin
            link.cmd_start <= 1'b1;
            state          <= sd_seq_state_t'(state + 1'b1);
          end
        end
        seq_done, seq_error: ;
        default: begin
          // wait states, judge the response
          if (link.cmd_done) begin
            if (link.resp_timeout) begin
              state <= seq_error;
            end else begin
              case (state)
                seq_cmd0_wait: begin
                  if (r1 == 8'h01) begin
                    state <= seq_cmd8;
                  end else if (retry_cnt == `SD_RETRY_LIMIT - 1) begin
                    state <= seq_error;
                  end else begin
                    retry_cnt <= retry_cnt + 1'b1;
                    state     <= seq_cmd0;
                  end
                end
                seq_cmd8_wait: begin
                  retry_cnt <= '0;
                  // 05 is illegal command, a v1 card
                  if (r1 == 8'h05 || (r1 == 8'h01 && link.resp[15:8] == 8'h01 &&
                      link.resp[7:0] == `SD_CHECK_PATTERN)) begin
                    state <= seq_cmd58a;
                  end else begin
                    state <= seq_error;
                  end
                end
                seq_cmd58a_wait: state <= seq_cmd55;
                seq_cmd55_wait: state <= seq_acmd41;
                seq_acmd41_wait: begin
                  if (r1 == 8'h00) begin
                    state <= seq_cmd58b;
                  end else if (r1 == 8'h01 && retry_cnt != `SD_RETRY_LIMIT - 1) begin
                    retry_cnt <= retry_cnt + 1'b1;
                    state     <= seq_cmd55;
                  end else begin
                    state <= seq_error;
                  end
                end
                seq_cmd58b_wait: begin
                  // ocr bit 30, ccs
                  card_high_capacity <= link.resp[30];
                  fast_sel           <= 1'b1;
                  state              <= seq_cmd16;
                end
                seq_cmd16_wait: state <= (r1 == 8'h00) ? seq_cmd17 : seq_error;
                seq_cmd17_wait: state <= (r1 == 8'h00) ? seq_done : seq_error;
                default: state <= seq_error;
              endcase
            end
          end
        end
      endcase
      // final levels, release the card
      if (state == seq_done) begin
        init_done      <= 1'b1;
        link.cs_active <= 1'b0;
      end
      if (state == seq_error) begin
        init_error     <= 1'b1;
        link.cs_active <= 1'b0;
      end
    end
  end

endmodule

// ==== source/sd_spi_engine.sv ====
`timescale 1ns/1ps
`include "sd_macros.svh"

module sd_spi_engine import sd_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  sclk_rise,
  input  logic  sclk_fall,
  input  logic  sd_miso,
  input  logic  block_complete,
  sd_cmd_if.eng link,
  output logic  sd_mosi,
  output logic  sd_cs_n,
  output logic  data_bit,
  output logic  data_bit_valid,
  output logic  block_start
);

  // bits covered by the crc, start bits to argument
  localparam int crc_span = `SD_FRAME_BITS - 8;
  localparam int crc_tail = 16;

  typedef enum logic [2:0] {
    eng_idle,
    eng_send,
    eng_resp,
    eng_token,
    eng_data,
    eng_crc
  } eng_state_t;

  eng_state_t  state;
  sd_frame_t   frame_sh;
  logic [6:0]  crc;
  logic [6:0]  crc_next;
  sd_bit_cnt_t bit_cnt;
  sd_bit_cnt_t wait_cnt;
  logic        rx_started;
  sd_byte_t    tok_sh;
  sd_byte_t    tok_byte;

  // serial crc7, x^7 + x^3 + 1
  function automatic logic [6:0] crc7_step(input logic [6:0] crc_in, input logic din);
    logic fb;
    fb = din ^ crc_in[6];
    return {crc_in[5:3], crc_in[2] ^ fb, crc_in[1:0], fb};
  endfunction

  assign crc_next = crc7_step(crc, frame_sh[`SD_FRAME_BITS-1]);
  assign tok_byte = {tok_sh[6:0], sd_miso};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state             <= eng_idle;
      frame_sh          <= '1;
      crc               <= '0;
      bit_cnt           <= '0;
      wait_cnt          <= '0;
      rx_started        <= 1'b0;
      tok_sh            <= '1;
      sd_mosi           <= 1'b1;
      sd_cs_n           <= 1'b1;
      data_bit          <= 1'b0;
      data_bit_valid    <= 1'b0;
      block_start       <= 1'b0;
      link.busy         <= 1'b0;
      link.cmd_done     <= 1'b0;
      link.resp         <= '1;
      link.resp_timeout <= 1'b0;
    end else begin
      sd_cs_n        <= ~link.cs_active;
      link.cmd_done  <= 1'b0;
      data_bit_valid <= 1'b0;
      block_start    <= 1'b0;
      case (state)
        eng_idle: begin
          if (link.cmd_start) begin
            // crc field zero until filled in after bit 39
            frame_sh          <= {2'b01, link.cmd_idx, link.cmd_arg, 7'h00, 1'b1};
            crc               <= '0;
            bit_cnt           <= '0;
            wait_cnt          <= '0;
            rx_started        <= 1'b0;
            link.resp         <= '1;
            link.resp_timeout <= 1'b0;
            link.busy         <= 1'b1;
            state             <= eng_send;
          end
        end
        eng_send: begin
          // mosi changes on the falling edge
          if (sclk_fall) begin
            sd_mosi <= frame_sh[`SD_FRAME_BITS-1];
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt < crc_span) begin
              crc <= crc_next;
            end
            if (bit_cnt == crc_span - 1) begin
              // crc, end bit, then idle ones
              frame_sh <= {crc_next, {(`SD_FRAME_BITS - 7){1'b1}}};
            end else begin
              frame_sh <= {frame_sh[`SD_FRAME_BITS-2:0], 1'b1};
            end
            if (bit_cnt == `SD_FRAME_BITS - 1) begin
              bit_cnt <= '0;
              state   <= eng_resp;
            end
          end
        end
        eng_resp: begin
          if (sclk_rise) begin
            // response starts with a zero bit
            if (rx_started || !sd_miso) begin
              rx_started                                <= 1'b1;
              link.resp[(`SD_R3_BITS - 1) - bit_cnt] <= sd_miso;
              bit_cnt                                   <= bit_cnt + 1'b1;
              if (bit_cnt == link.resp_len - 1'b1) begin
                bit_cnt  <= '0;
                wait_cnt <= '0;
                if (link.want_block) begin
                  state <= eng_token;
                end else begin
                  link.cmd_done <= 1'b1;
                  link.busy     <= 1'b0;
                  state         <= eng_idle;
                end
              end
            end else if (wait_cnt == `SD_RESP_TIMEOUT - 1) begin
              link.resp_timeout <= 1'b1;
              link.cmd_done     <= 1'b1;
              link.busy         <= 1'b0;
              state             <= eng_idle;
            end else begin
              wait_cnt <= wait_cnt + 1'b1;
            end
          end
        end
        eng_token: begin
          // byte aligned search for the start block token
          if (sclk_rise) begin
            tok_sh  <= tok_byte;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 7) begin
              bit_cnt <= '0;
              if (tok_byte == `SD_DATA_TOKEN) begin
                block_start <= 1'b1;
                state       <= eng_data;
              end else if (wait_cnt == `SD_TOKEN_TIMEOUT - 1) begin
                link.resp_timeout <= 1'b1;
                link.cmd_done     <= 1'b1;
                link.busy         <= 1'b0;
                state             <= eng_idle;
              end else begin
                wait_cnt <= wait_cnt + 1'b1;
              end
            end
          end
        end
        eng_data: begin
          // a rise landing with block_complete is already the first crc bit
          if (block_complete) begin
            bit_cnt <= sd_bit_cnt_t'(sclk_rise);
            state   <= eng_crc;
          end else if (sclk_rise) begin
            data_bit       <= sd_miso;
            data_bit_valid <= 1'b1;
          end
        end
        eng_crc: begin
          // data crc clocked through, not checked
          if (sclk_rise) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == crc_tail - 1) begin
              link.cmd_done <= 1'b1;
              link.busy     <= 1'b0;
              state         <= eng_idle;
            end
          end
        end
        default: state <= eng_idle;
      endcase
    end
  end

endmodule

// ==== source/sd_block_assembler.sv ====
`timescale 1ns/1ps
`include "sd_macros.svh"

module sd_block_assembler import sd_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     data_bit,
  input  logic     data_bit_valid,
  input  logic     block_start,
  output sd_byte_t block_byte,
  output logic     block_byte_valid,
  output logic     block_complete
);

  // first seven bits of the current byte, msb first
  logic [6:0]  byte_sh;
  logic [2:0]  bit_cnt;
  sd_bit_cnt_t byte_cnt;
  logic        active;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt          <= '0;
      byte_cnt         <= '0;
      active           <= 1'b0;
      block_byte_valid <= 1'b0;
      block_complete   <= 1'b0;
    end else begin
      block_byte_valid <= 1'b0;
      block_complete   <= 1'b0;
      if (block_start) begin
        bit_cnt  <= '0;
        byte_cnt <= '0;
        active   <= 1'b1;
      end else if (active && data_bit_valid) begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == 3'd7) begin
          block_byte_valid <= 1'b1;
          byte_cnt         <= byte_cnt + 1'b1;
          // last byte of the block
          if (byte_cnt == `SD_BLOCK_BYTES - 1) begin
            block_complete <= 1'b1;
            active         <= 1'b0;
          end
        end
      end
    end
  end

  // byte data path
  always_ff @(posedge clk) begin
    if (active && data_bit_valid) begin
      byte_sh <= {byte_sh[5:0], data_bit};
      if (bit_cnt == 3'd7) begin
        block_byte <= {byte_sh, data_bit};
      end
    end
  end

endmodule

// ==== source/sd_card_init_top.sv ====
`timescale 1ns/1ps

module sd_card_init_top import sd_pkg::*; #(
  parameter int slow_div = 125,
  parameter int fast_div = 2
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     sd_miso,
  output logic     sd_sclk,
  output logic     sd_mosi,
  output logic     sd_cs_n,
  output logic     init_done,
  output logic     init_error,
  output logic     card_high_capacity,
  output sd_byte_t block_byte,
  output logic     block_byte_valid
);

  logic sclk_rise;
  logic sclk_fall;
  logic fast_sel;
  logic data_bit;
  logic data_bit_valid;
  logic block_start;
  logic block_complete;

  // sequencer to engine command link
  sd_cmd_if link ();

  sd_sclk_gen #(
    .slow_div(slow_div),
    .fast_div(fast_div)
  ) u_sclk_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .fast_sel (fast_sel),
    .sd_sclk  (sd_sclk),
    .sclk_rise(sclk_rise),
    .sclk_fall(sclk_fall)
  );

  sd_init_sequencer u_sequencer (
    .clk               (clk),
    .rst_n             (rst_n),
    .sclk_rise         (sclk_rise),
    .link              (link.seq),
    .fast_sel          (fast_sel),
    .init_done         (init_done),
    .init_error        (init_error),
    .card_high_capacity(card_high_capacity)
  );

  sd_spi_engine u_engine (
    .clk           (clk),
    .rst_n         (rst_n),
    .sclk_rise     (sclk_rise),
    .sclk_fall     (sclk_fall),
    .sd_miso       (sd_miso),
    .block_complete(block_complete),
    .link          (link.eng),
    .sd_mosi       (sd_mosi),
    .sd_cs_n       (sd_cs_n),
    .data_bit      (data_bit),
    .data_bit_valid(data_bit_valid),
    .block_start   (block_start)
  );

  sd_block_assembler u_assembler (
    .clk             (clk),
    .rst_n           (rst_n),
    .data_bit        (data_bit),
    .data_bit_valid  (data_bit_valid),
    .block_start     (block_start),
    .block_byte      (block_byte),
    .block_byte_valid(block_byte_valid),
    .block_complete  (block_complete)
  );

endmodule

// ==== tb/sd_card_model.sv ====
`timescale 1ns/1ps

module sd_card_model (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sd_sclk,
  input  logic       sd_cs_n,
  input  logic       sd_mosi,
  output logic       sd_miso,
  // card personality, set by the testbench before reset
  input  logic       v2_card,
  input  int         idle_replies,
  input  logic [7:0] echo,
  input  logic       high_cap,
  input  logic       silent,
  // observations
  output int         acmd41_count,
  output int         cmd55_count,
  output logic       frame_error
);

  // block 0 contents
  logic [7:0]  data_mem [0:511];
  integer      seed;
  logic        sclk_q;
  logic [47:0] rx_sh;
  int          rx_cnt;
  logic        idle;
  // bits waiting to go out on miso, msb first
  logic        tx_q[$];

  initial begin
    logic [31:0] rnd;
    sd_miso     = 1'b1;
    frame_error = 1'b0;
    seed        = 58573;
    for (int i = 0; i < 512; i++) begin
      rnd         = $random(seed);
      data_mem[i] = rnd[7:0];
    end
  end

  // crc7 by long division, generator 0x89
  function automatic logic [6:0] frame_crc7(input logic [39:0] bits);
    logic [6:0] rem;
    rem = 7'h00;
    for (int i = 39; i >= 0; i--) begin
      if (bits[i] ^ rem[6]) begin
        rem = {rem[5:0], 1'b0} ^ 7'h09;
      end else begin
        rem = {rem[5:0], 1'b0};
      end
    end
    return rem;
  endfunction

  task automatic push_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      tx_q.push_back(b[i]);
    end
  endtask

  task automatic push_ones(input int n);
    for (int i = 0; i < n; i++) begin
      tx_q.push_back(1'b1);
    end
  endtask

  // decode one received frame and queue the reply
  task automatic answer(input logic [47:0] frame);
    logic [5:0]  idx;
    logic [31:0] arg;
    idx = frame[45:40];
    arg = frame[39:8];
    if (frame[47:46] != 2'b01 || frame[7:1] != frame_crc7(frame[39+8:8]) || !frame[0]) begin
      $display("card model: CMD%0d frame %h has a bad start, CRC7 or end bit", idx, frame);
      frame_error <= 1'b1;
    end
    // two well known frames as a fixed reference
    if (idx == 6'd0 && arg == 32'h0 && frame[7:0] != 8'h95) begin
      $display("card model: CMD0 frame does not end in 95, got %h", frame[7:0]);
      frame_error <= 1'b1;
    end
    if (idx == 6'd8 && arg == 32'h1AA && frame[7:0] != 8'h87) begin
      $display("card model: CMD8 frame does not end in 87, got %h", frame[7:0]);
      frame_error <= 1'b1;
    end
    if (!silent) begin
      // ncr gap before the response
      push_ones(8);
      case (idx)
        6'd0: begin
          idle = 1'b1;
          push_byte(8'h01);
        end
        6'd8: begin
          if (v2_card) begin
            push_byte(8'h01);
            push_byte(8'h00);
            push_byte(8'h00);
            push_byte({4'h0, arg[11:8]});
            push_byte(echo);
          end else begin
            // illegal command, v1 card
            push_byte(8'h05);
          end
        end
        6'd58: begin
          // ocr, power up done and ccs once out of idle
          push_byte({7'h00, idle});
          push_byte({~idle, high_cap & ~idle, 6'h00});
          push_byte(8'hFF);
          push_byte(8'h80);
          push_byte(8'h00);
        end
        6'd55: begin
          cmd55_count++;
          push_byte({7'h00, idle});
        end
        6'd41: begin
          acmd41_count++;
          if (acmd41_count > idle_replies) begin
            idle = 1'b0;
          end
          push_byte({7'h00, idle});
        end
        6'd16: push_byte(8'h00);
        6'd17: begin
          // r1, nac gap, start block token, data, crc16
          push_byte(8'h00);
          push_ones(16);
          push_byte(8'hFE);
          for (int i = 0; i < 512; i++) begin
            push_byte(data_mem[i]);
          end
          push_byte(8'h5A);
          push_byte(8'hC3);
        end
        default: push_byte(8'h04);
      endcase
    end
  endtask

  // sclk edges seen one clk late, miso moves after the falling edge
  always @(posedge clk) begin
    sclk_q <= sd_sclk;
    if (!rst_n) begin
      sd_miso      <= 1'b1;
      frame_error  <= 1'b0;
      rx_cnt       = 0;
      idle         = 1'b1;
      acmd41_count = 0;
      cmd55_count  = 0;
      tx_q.delete();
    end else if (sd_cs_n) begin
      sd_miso <= 1'b1;
      rx_cnt  = 0;
    end else begin
      if (sclk_q && !sd_sclk) begin
        if (tx_q.size() > 0) begin
          sd_miso <= tx_q.pop_front();
        end else begin
          sd_miso <= 1'b1;
        end
      end
      // frame starts at the first zero on mosi
      if (!sclk_q && sd_sclk && (rx_cnt > 0 || !sd_mosi)) begin
        rx_sh = {rx_sh[46:0], sd_mosi};
        rx_cnt++;
        if (rx_cnt == 48) begin
          rx_cnt = 0;
          answer(rx_sh);
        end
      end
    end
  end

endmodule

// ==== tb/tb_sd_card_init.sv ====
`timescale 1ns/1ps
`include "sd_macros.svh"

module tb_sd_card_init;

  localparam int slow_div = 4;
  localparam int fast_div = 1;
  // clk cycles
  localparam int done_timeout = 100000;
  localparam int cs_timeout   = 2000;
  localparam int edge_timeout = 200;

  logic       clk;
  logic       rst_n;
  logic       sd_miso;
  logic       sd_sclk;
  logic       sd_mosi;
  logic       sd_cs_n;
  logic       init_done;
  logic       init_error;
  logic       card_high_capacity;
  logic [7:0] block_byte;
  logic       block_byte_valid;

  // card personality
  logic       v2_card;
  int         idle_replies;
  logic [7:0] echo;
  logic       high_cap;
  logic       silent;
  int         acmd41_count;
  int         cmd55_count;
  logic       frame_error;

  // received block bytes and the clk cycle of each strobe
  int         cycle;
  logic [7:0] rx_bytes[$];
  int         rx_times[$];

  sd_card_init_top #(
    .slow_div(slow_div),
    .fast_div(fast_div)
  ) dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .sd_miso           (sd_miso),
    .sd_sclk           (sd_sclk),
    .sd_mosi           (sd_mosi),
    .sd_cs_n           (sd_cs_n),
    .init_done         (init_done),
    .init_error        (init_error),
    .card_high_capacity(card_high_capacity),
    .block_byte        (block_byte),
    .block_byte_valid  (block_byte_valid)
  );

  sd_card_model card (
    .clk         (clk),
    .rst_n       (rst_n),
    .sd_sclk     (sd_sclk),
    .sd_cs_n     (sd_cs_n),
    .sd_mosi     (sd_mosi),
    .sd_miso     (sd_miso),
    .v2_card     (v2_card),
    .idle_replies(idle_replies),
    .echo        (echo),
    .high_cap    (high_cap),
    .silent      (silent),
    .acmd41_count(acmd41_count),
    .cmd55_count (cmd55_count),
    .frame_error (frame_error)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (block_byte_valid) begin
      rx_bytes.push_back(block_byte);
      rx_times.push_back(cycle);
    end
  end

  // crc or framing fault flagged by the card
  always @(posedge clk) begin
    assert (frame_error !== 1'b1)
      else abort_run("the card model received a malformed command frame");
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic set_card(input logic v2, input int idle_n, input logic [7:0] echo_byte,
                          input logic hc, input logic quiet);
    @(posedge clk);
    v2_card      <= v2;
    idle_replies <= idle_n;
    echo         <= echo_byte;
    high_cap     <= hc;
    silent       <= quiet;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (4) @(posedge clk);
    // all outputs inactive while reset is held
    assert (sd_cs_n === 1'b1 && sd_mosi === 1'b1 && sd_sclk === 1'b0 &&
            init_done === 1'b0 && init_error === 1'b0 &&
            block_byte_valid === 1'b0 && card_high_capacity === 1'b0)
      else abort_run($sformatf("error at %0t ns: outputs not inactive in reset", $time));
    rx_bytes.delete();
    rx_times.delete();
    rst_n <= 1'b1;
  endtask

  task automatic wait_cs_low();
    int n;
    n = 0;
    while (sd_cs_n && n < cs_timeout) begin
      @(posedge clk);
      n++;
    end
    if (n >= cs_timeout) begin
      abort_run("chip select never went low after the power-up wait");
    end
  endtask

  // length of the next full sclk high phase in clk cycles
  task automatic measure_sclk_high(output int high_clks);
    int n;
    n         = 0;
    high_clks = 0;
    while (sd_sclk && n < edge_timeout) begin
      @(posedge clk);
      n++;
    end
    while (!sd_sclk && n < edge_timeout) begin
      @(posedge clk);
      n++;
    end
    while (sd_sclk && n < edge_timeout) begin
      @(posedge clk);
      n++;
      high_clks++;
    end
    if (n >= edge_timeout) begin
      abort_run("sclk stopped toggling");
    end
  endtask

  task automatic wait_first_byte();
    int n;
    n = 0;
    while (rx_bytes.size() == 0 && !init_error && n < done_timeout) begin
      @(posedge clk);
      n++;
    end
    assert (!init_error)
      else abort_run($sformatf("error at %0t ns: init_error before the first byte", $time));
    if (n >= done_timeout) begin
      abort_run("timed out waiting for the first block byte");
    end
  endtask

  task automatic wait_for_end();
    int n;
    n = 0;
    while (!init_done && !init_error && n < done_timeout) begin
      @(posedge clk);
      n++;
    end
    if (n >= done_timeout) begin
      abort_run("timed out waiting for init_done or init_error");
    end
  endtask

  // 512 bytes in card order, one strobe per 8 fast sclk periods
  task automatic check_block();
    int gap;
    assert (rx_bytes.size() == 512)
      else abort_run($sformatf("error at %0t ns: %0d block bytes, expected 512",
                               $time, rx_bytes.size()));
    for (int i = 0; i < 512; i++) begin
      assert (rx_bytes[i] === card.data_mem[i])
        else abort_run($sformatf("error at %0t ns: byte %0d is %h, expected %h",
                                 $time, i, rx_bytes[i], card.data_mem[i]));
      if (i > 0) begin
        gap = rx_times[i] - rx_times[i-1];
        assert (gap == 16 * fast_div)
          else abort_run($sformatf("error at %0t ns: byte %0d came %0d clk after the last",
                                   $time, i, gap));
      end
    end
  endtask

  task automatic v2_card_reads_block();
    int high_clks;
    set_card(1'b1, 3, 8'hAA, 1'b1, 1'b0);
    apply_reset();
    wait_cs_low();
    // first sclk pulses belong to cmd0
    measure_sclk_high(high_clks);
    assert (high_clks == slow_div)
      else abort_run($sformatf("error at %0t ns: sclk high %0d clk in CMD0, expected %0d",
                               $time, high_clks, slow_div));
    wait_first_byte();
    measure_sclk_high(high_clks);
    assert (high_clks == fast_div)
      else abort_run($sformatf("error at %0t ns: sclk high %0d clk in block, expected %0d",
                               $time, high_clks, fast_div));
    wait_for_end();
    assert (init_done && !init_error)
      else abort_run($sformatf("error at %0t ns: v2 card did not finish cleanly", $time));
    assert (card_high_capacity === 1'b1)
      else abort_run($sformatf("error at %0t ns: card_high_capacity not set", $time));
    // three idle replies, then ready
    assert (acmd41_count == 4)
      else abort_run($sformatf("error at %0t ns: %0d ACMD41 frames, expected 4",
                               $time, acmd41_count));
    check_block();
  endtask

  task automatic v1_card_reads_block();
    set_card(1'b0, 1, 8'hAA, 1'b0, 1'b0);
    apply_reset();
    wait_for_end();
    assert (init_done && !init_error)
      else abort_run($sformatf("error at %0t ns: v1 card did not finish cleanly", $time));
    assert (card_high_capacity === 1'b0)
      else abort_run($sformatf("error at %0t ns: card_high_capacity set on v1 card", $time));
    check_block();
  endtask

  task automatic acmd41_never_ready();
    set_card(1'b1, 1000, 8'hAA, 1'b1, 1'b0);
    apply_reset();
    wait_for_end();
    assert (init_error && !init_done)
      else abort_run($sformatf("error at %0t ns: no error for a card stuck in idle", $time));
    assert (acmd41_count == `SD_RETRY_LIMIT)
      else abort_run($sformatf("error at %0t ns: %0d ACMD41 frames, expected %0d",
                               $time, acmd41_count, `SD_RETRY_LIMIT));
  endtask

  task automatic bad_cmd8_echo();
    set_card(1'b1, 3, 8'h55, 1'b1, 1'b0);
    apply_reset();
    wait_for_end();
    assert (init_error && !init_done)
      else abort_run($sformatf("error at %0t ns: no error for a wrong CMD8 echo", $time));
    assert (cmd55_count == 0)
      else abort_run($sformatf("error at %0t ns: %0d CMD55 frames after a bad echo",
                               $time, cmd55_count));
  endtask

  task automatic silent_card_fails();
    set_card(1'b1, 3, 8'hAA, 1'b1, 1'b1);
    apply_reset();
    wait_for_end();
    assert (init_error && !init_done)
      else abort_run($sformatf("error at %0t ns: no error for a silent card", $time));
    assert (rx_bytes.size() == 0)
      else abort_run($sformatf("error at %0t ns: %0d block bytes from a silent card",
                               $time, rx_bytes.size()));
  endtask

  initial begin
    rst_n        = 1'b0;
    cycle        = 0;
    v2_card      = 1'b1;
    idle_replies = 0;
    echo         = 8'hAA;
    high_cap     = 1'b0;
    silent       = 1'b0;
    v2_card_reads_block();
    v1_card_reads_block();
    acmd41_never_ready();
    bad_cmd8_echo();
    silent_card_fails();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+source
source/sd_pkg.sv
source/sd_cmd_if.sv
source/sd_sclk_gen.sv
source/sd_init_sequencer.sv
source/sd_spi_engine.sv
source/sd_block_assembler.sv
source/sd_card_init_top.sv
tb/sd_card_model.sv
tb/tb_sd_card_init.sv

// ==== Bender.yml ====
package:
  name: sd_card_init

sources:
  - include_dirs:
      - source
    files:
      - source/sd_pkg.sv
      - source/sd_cmd_if.sv
      - source/sd_sclk_gen.sv
      - source/sd_init_sequencer.sv
      - source/sd_spi_engine.sv
      - source/sd_block_assembler.sv
      - source/sd_card_init_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/sd_card_model.sv
      - tb/tb_sd_card_init.sv
